//--- bench/tb_ex_stage.sv
`timescale 1ns/10ps

module tb_ex_stage import ex_pkg::*; ();

    localparam int          CLK_PERIOD = 10;
    localparam int          N_OPS      = 2000;
    localparam logic [31:0] SEED       = 32'h3ce4;
    localparam int          TIMEOUT_NS = N_OPS * CLK_PERIOD * 4 + 500;

    // DUT inputs
    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    logic        alu_valid_i;
    logic        mult_valid_i;
    logic        csr_valid_i;
    logic [3:0]  operation_i;
    logic [31:0] operand_a_i;
    logic [31:0] operand_b_i;
    logic [2:0]  trans_id_i;
    logic        csr_commit_i;

    // DUT outputs
    logic        flu_ready_o;
    logic        flu_valid_o;
    logic [31:0] flu_result_o;
    logic [2:0]  flu_trans_id_o;
    logic [11:0] csr_addr_o;

    // Stimulus for the next cycle
    logic        nxt_flush;
    logic        nxt_alu;
    logic        nxt_mult;
    logic        nxt_csr;
    logic        nxt_commit;
    logic [3:0]  nxt_op;
    logic [31:0] nxt_a;
    logic [31:0] nxt_b;
    logic [31:0] r_id;

    // Reference model state
    logic        slot1_valid;
    logic        slot2_valid;
    logic [31:0] slot1_result;
    logic [31:0] slot2_result;
    logic [2:0]  slot1_id;
    logic [2:0]  slot2_id;
    logic        full_m;
    logic [11:0] addr_m;
    logic [31:0] lfsr;
    int          issued;

    ex_stage ex_stage_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: the run timed out before all operations were issued");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    // ------------------------------
    // Random bits and checks
    // ------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            // Logical shift, then fill the vacated top bits with the sign
            OP_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            OP_SLT:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            OP_SLTU: return {31'b0, a < b};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] mult_model(input logic [3:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [63:0] wa;
        logic [63:0] wb;
        logic [63:0] prod;
        wa = {32'b0, a};
        wb = {32'b0, b};
        if (op == OP_MULH || op == OP_MULHSU) wa = {{32{a[31]}}, a};
        if (op == OP_MULH) wb = {{32{b[31]}}, b};
        prod = wa * wb;
        return (op == OP_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    // Compare this cycle's outputs, then move the model one edge on
    task automatic check_cycle();
        logic        exp_valid;
        logic [31:0] exp_result;
        logic [2:0]  exp_id;
        exp_valid  = slot2_valid || alu_valid_i || csr_valid_i;
        exp_id     = slot2_valid ? slot2_id : trans_id_i;
        exp_result = operand_a_i;
        if (slot2_valid) exp_result = slot2_result;
        else if (alu_valid_i) exp_result = alu_model(operation_i, operand_a_i, operand_b_i);
        check_value("flu_ready_o", 32'(flu_ready_o), 32'(!slot2_valid && !full_m));
        check_value("flu_valid_o", 32'(flu_valid_o), 32'(exp_valid));
        if (exp_valid) begin
            check_value("flu_result_o", flu_result_o, exp_result);
            check_value("flu_trans_id_o", 32'(flu_trans_id_o), 32'(exp_id));
        end
        check_value("csr_addr_o", 32'(csr_addr_o), 32'(addr_m));
        slot2_valid  = slot1_valid && !flush_i;
        slot2_result = slot1_result;
        slot2_id     = slot1_id;
        slot1_valid  = mult_valid_i && !flush_i;
        slot1_result = mult_model(operation_i, operand_a_i, operand_b_i);
        slot1_id     = trans_id_i;
        if (csr_valid_i && !flush_i) addr_m = operand_b_i[11:0];
        if (flush_i || csr_commit_i) full_m = 1'b0;
        else if (csr_valid_i) full_m = 1'b1;
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    // Model state now describes the next cycle, so it predicts ready
    task automatic plan_next();
        logic [31:0] r;
        nxt_alu    = 1'b0;
        nxt_mult   = 1'b0;
        nxt_csr    = 1'b0;
        nxt_commit = 1'b0;
        take_bits(6, r);
        nxt_flush = (r[5:0] == 6'd0);
        if (full_m) begin
            take_bits(2, r);
            nxt_commit = (r[1:0] == 2'd0);
        end
        if (!slot2_valid && !full_m && !nxt_flush && issued < N_OPS) begin
            take_bits(32, nxt_a);
            take_bits(32, nxt_b);
            take_bits(3, r_id);
            take_bits(3, r);
            nxt_alu  = (r[2:0] >= 3'd1) && (r[2:0] <= 3'd3);
            nxt_mult = (r[2:0] >= 3'd4) && (r[2:0] <= 3'd6);
            nxt_csr  = (r[2:0] == 3'd7);
            nxt_op   = OP_ADD;
            if (nxt_alu) begin
                take_bits(4, r);
                nxt_op = 4'(r % 10);
            end else if (nxt_mult) begin
                take_bits(2, r);
                nxt_op = OP_MUL + {2'b00, r[1:0]};
            end
            if (nxt_alu || nxt_mult || nxt_csr) issued++;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk_i);
        flush_i      <= nxt_flush;
        alu_valid_i  <= nxt_alu;
        mult_valid_i <= nxt_mult;
        csr_valid_i  <= nxt_csr;
        csr_commit_i <= nxt_commit;
        operation_i  <= nxt_op;
        operand_a_i  <= nxt_a;
        operand_b_i  <= nxt_b;
        trans_id_i   <= r_id[2:0];
        @(negedge clk_i);
        check_cycle();
        plan_next();
    endtask

    initial begin
        rst_ni       = 1'b0;
        flush_i      = 1'b0;
        alu_valid_i  = 1'b0;
        mult_valid_i = 1'b0;
        csr_valid_i  = 1'b0;
        csr_commit_i = 1'b0;
        operation_i  = '0;
        operand_a_i  = '0;
        operand_b_i  = '0;
        trans_id_i   = '0;
        nxt_op       = OP_ADD;
        nxt_a        = '0;
        nxt_b        = '0;
        r_id         = '0;
        lfsr         = SEED;
        issued       = 0;
        slot1_valid  = 1'b0;
        slot2_valid  = 1'b0;
        full_m       = 1'b0;
        addr_m       = '0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        // Idle state straight out of reset
        check_value("flu_valid_o", 32'(flu_valid_o), 32'h0);
        check_value("flu_ready_o", 32'(flu_ready_o), 32'h1);
        check_value("csr_addr_o", 32'(csr_addr_o), 32'h0);
        plan_next();
        while (issued < N_OPS) run_cycle();
        // Let the last multiplies reach the port
        repeat (3) run_cycle();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- common/ex_pkg.sv
package ex_pkg;

    // ------------------------------
    // Datapath widths
    // ------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;
    localparam int unsigned OP_BITS       = 4;

    // ------------------------------
    // Operation codes
    // ------------------------------

    // ALU operations
    localparam logic [OP_BITS-1:0] OP_ADD    = 4'd0;
    localparam logic [OP_BITS-1:0] OP_SUB    = 4'd1;
    localparam logic [OP_BITS-1:0] OP_XOR    = 4'd2;
    localparam logic [OP_BITS-1:0] OP_OR     = 4'd3;
    localparam logic [OP_BITS-1:0] OP_AND    = 4'd4;

    // Shifts by the low five bits of operand b
    localparam logic [OP_BITS-1:0] OP_SLL    = 4'd5;
    localparam logic [OP_BITS-1:0] OP_SRL    = 4'd6;
    localparam logic [OP_BITS-1:0] OP_SRA    = 4'd7;

    // Comparisons, result is 0 or 1
    localparam logic [OP_BITS-1:0] OP_SLT    = 4'd8;
    localparam logic [OP_BITS-1:0] OP_SLTU   = 4'd9;

    // Multiplier operations
    // MUL returns the low word, the rest the high word
    localparam logic [OP_BITS-1:0] OP_MUL    = 4'd10;
    localparam logic [OP_BITS-1:0] OP_MULH   = 4'd11;
    localparam logic [OP_BITS-1:0] OP_MULHU  = 4'd12;
    localparam logic [OP_BITS-1:0] OP_MULHSU = 4'd13;

    // ------------------------------
    // Second operand
    // ------------------------------

    // ALU and multiplier use the data view.
    // CSR instructions carry the CSR address in the low bits.
    typedef union packed {
        logic [XLEN-1:0] data;
        struct packed {
            logic [XLEN-CSR_ADDR_BITS-1:0] reserved;
            logic [CSR_ADDR_BITS-1:0]      csr_addr;
        } csr;
    } operand_t;

endpackage

//--- logic/alu.sv
`timescale 1ns/10ps

module alu import ex_pkg::*; (
    input  logic               alu_valid_i,
    input  logic [OP_BITS-1:0] operation_i,
    input  logic [XLEN-1:0]    operand_a_i,
    input  operand_t           operand_b_i,
    output logic [XLEN-1:0]    result_o
);

    // Silenced operands
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    // Shared adder
    logic                    subtract;
    logic [XLEN-1:0]         adder_b;
    logic [XLEN-1:0]         adder_sum;

    // Shifter and comparator
    logic [$clog2(XLEN)-1:0] shamt;
    logic                    less_signed;
    logic                    less_unsigned;

    // ------------------------------
    // Input silencing
    // ------------------------------

    // Idle cycles keep the adder and shifter inputs at zero
    assign op_a = alu_valid_i ? operand_a_i       : '0;
    assign op_b = alu_valid_i ? operand_b_i.data  : '0;

    // ------------------------------
    // Arithmetic
    // ------------------------------
    assign subtract  = (operation_i == OP_SUB);
    assign adder_b   = subtract ? ~op_b : op_b;
    // Two's complement subtract via carry in
    assign adder_sum = op_a + adder_b + {{(XLEN-1){1'b0}}, subtract};

    assign shamt         = op_b[$clog2(XLEN)-1:0];
    assign less_signed   = ($signed(op_a) < $signed(op_b));
    assign less_unsigned = (op_a < op_b);

    // ------------------------------
    // Result select
    // ------------------------------
    always_comb begin
        result_o = '0;
        unique case (operation_i)
            OP_ADD,
            OP_SUB:  result_o = adder_sum;
            OP_XOR:  result_o = op_a ^ op_b;
            OP_OR:   result_o = op_a | op_b;
            OP_AND:  result_o = op_a & op_b;
            OP_SLL:  result_o = op_a << shamt;
            OP_SRL:  result_o = op_a >> shamt;
            OP_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, less_signed};
            OP_SLTU: result_o = {{(XLEN-1){1'b0}}, less_unsigned};
            // Multiplier opcodes never reach a valid ALU issue
            default: result_o = '0;
        endcase
    end

endmodule

//--- logic/csr_buffer.sv
`timescale 1ns/10ps

module csr_buffer import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     csr_valid_i,
    input  logic                     csr_commit_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_t                 operand_b_i,
    output logic                     csr_ready_o,
    output logic [XLEN-1:0]          csr_result_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    // One entry, address only
    logic                     full_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    // ------------------------------
    // Entry state
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end else if (csr_commit_i) begin
            full_q <= 1'b0;
        end
    end

    // Address is visible to the CSR file after reset as zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q <= '0;
        end else if (csr_valid_i && !flush_i) begin
            addr_q <= operand_b_i.csr.csr_addr;
        end
    end

    // Blocks further issue until the CSR instruction commits
    assign csr_ready_o  = ~full_q;
    // Write data goes straight back to the scoreboard
    assign csr_result_o = operand_a_i;
    assign csr_addr_o   = addr_q;

    // Issuer has to wait for ready before a second CSR op
    no_issue_when_full_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) csr_valid_i |-> !full_q
    ) else $error("CSR issued while the buffer still holds an entry");

endmodule

//--- logic/ex_stage.sv
`timescale 1ns/10ps

module ex_stage import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,

    // Issue port
    input  logic                     alu_valid_i,
    input  logic                     mult_valid_i,
    input  logic                     csr_valid_i,
    input  logic [OP_BITS-1:0]       operation_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_t                 operand_b_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,

    // CSR commit from the scoreboard
    input  logic                     csr_commit_i,

    // Writeback port
    output logic                     flu_ready_o,
    output logic                     flu_valid_o,
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o,

    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic [XLEN-1:0]          alu_result;
    logic [XLEN-1:0]          csr_result;
    logic [XLEN-1:0]          mult_result;
    logic                     mult_valid;
    logic [TRANS_ID_BITS-1:0] mult_trans_id;
    logic                     csr_ready;

    // ------------------------------
    // Fixed latency units
    // ------------------------------

    // Single cycle
    alu alu_i (
        .alu_valid_i  ( alu_valid_i ),
        .operation_i  ( operation_i ),
        .operand_a_i  ( operand_a_i ),
        .operand_b_i  ( operand_b_i ),
        .result_o     ( alu_result  )
    );

    // Two cycles, fully pipelined
    mult_pipe mult_pipe_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .mult_valid_i,
        .operation_i,
        .operand_a_i,
        .operand_b_i,
        .trans_id_i,
        .result_o        ( mult_result   ),
        .mult_valid_o    ( mult_valid    ),
        .mult_trans_id_o ( mult_trans_id )
    );

    // Holds the CSR address until commit
    csr_buffer csr_buffer_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .csr_valid_i,
        .csr_commit_i,
        .operand_a_i,
        .operand_b_i,
        .csr_ready_o  ( csr_ready  ),
        .csr_result_o ( csr_result ),
        .csr_addr_o
    );

    // ------------------------------
    // Shared writeback
    // ------------------------------
    flu_writeback flu_writeback_i (
        .alu_valid_i,
        .csr_valid_i,
        .trans_id_i,
        .alu_result_i    ( alu_result    ),
        .csr_result_i    ( csr_result    ),
        .mult_result_i   ( mult_result   ),
        .mult_valid_i    ( mult_valid    ),
        .mult_trans_id_i ( mult_trans_id ),
        .csr_ready_i     ( csr_ready     ),
        .flu_valid_o,
        .flu_result_o,
        .flu_trans_id_o,
        .flu_ready_o
    );

endmodule

//--- logic/flu_writeback.sv
`timescale 1ns/10ps

module flu_writeback import ex_pkg::*; (
    input  logic                     alu_valid_i,
    input  logic                     csr_valid_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [XLEN-1:0]          alu_result_i,
    input  logic [XLEN-1:0]          csr_result_i,
    input  logic [XLEN-1:0]          mult_result_i,
    input  logic                     mult_valid_i,
    input  logic [TRANS_ID_BITS-1:0] mult_trans_id_i,
    input  logic                     csr_ready_i,
    output logic                     flu_valid_o,
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                     flu_ready_o
);

    // ------------------------------
    // Result mux
    // ------------------------------

    assign flu_valid_o = mult_valid_i | alu_valid_i | csr_valid_i;

    // Multiplier first since its result was issued two cycles ago
    // CSR result is the fallback
    always_comb begin
        flu_result_o   = csr_result_i;
        flu_trans_id_o = trans_id_i;
        if (mult_valid_i) begin
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end else if (alu_valid_i) begin
            flu_result_o   = alu_result_i;
        end
    end

    // ------------------------------
    // Issue readiness
    // ------------------------------

    // Port is taken by a multiply result this cycle
    // or the CSR entry is still waiting for commit
    assign flu_ready_o = ~mult_valid_i & csr_ready_i;

    // Single write port into the scoreboard
    always_comb begin
        one_writer_a: assert ($onehot0({mult_valid_i, alu_valid_i, csr_valid_i}))
            else $error("more than one unit drives the writeback port");
    end

endmodule

//--- multiplier/mult_pipe.sv
`timescale 1ns/10ps

module mult_pipe import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     mult_valid_i,
    input  logic [OP_BITS-1:0]       operation_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  operand_t                 operand_b_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    output logic [XLEN-1:0]          result_o,
    output logic                     mult_valid_o,
    output logic [TRANS_ID_BITS-1:0] mult_trans_id_o
);

    // Sign handling for the 33 bit operands
    logic                     sign_a;
    logic                     sign_b;
    logic [XLEN:0]            ext_a;
    logic [XLEN:0]            ext_b;

    // Stage 1
    logic                     stage1_valid_q;
    logic [XLEN:0]            stage1_a_q;
    logic [XLEN:0]            stage1_b_q;
    logic [OP_BITS-1:0]       stage1_op_q;
    logic [TRANS_ID_BITS-1:0] stage1_id_q;

    // Stage 2
    logic signed [2*XLEN+1:0] prod_full;
    logic                     stage2_valid_q;
    logic [2*XLEN-1:0]        stage2_prod_q;
    logic [OP_BITS-1:0]       stage2_op_q;
    logic [TRANS_ID_BITS-1:0] stage2_id_q;

    // ------------------------------
    // Operand extension
    // ------------------------------
    always_comb begin
        sign_a = 1'b0;
        sign_b = 1'b0;
        case (operation_i)
            OP_MULH: begin
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
            OP_MULHSU: sign_a = 1'b1;
            OP_MUL,
            OP_MULHU:  sign_a = 1'b0;
            default:   sign_a = 1'b0;
        endcase
    end

    // Operands stay zero while no multiply is issued
    assign ext_a = mult_valid_i ? {sign_a & operand_a_i[XLEN-1], operand_a_i} : '0;
    assign ext_b = mult_valid_i ? {sign_b & operand_b_i.data[XLEN-1], operand_b_i.data} : '0;

    assign prod_full = $signed(stage1_a_q) * $signed(stage1_b_q);

    // ------------------------------
    // Pipeline registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage1_valid_q <= 1'b0;
            stage2_valid_q <= 1'b0;
        end else if (flush_i) begin
            stage1_valid_q <= 1'b0;
            stage2_valid_q <= 1'b0;
        end else begin
            stage1_valid_q <= mult_valid_i;
            stage2_valid_q <= stage1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        stage1_a_q    <= ext_a;
        stage1_b_q    <= ext_b;
        stage1_op_q   <= operation_i;
        stage1_id_q   <= trans_id_i;
        stage2_prod_q <= prod_full[2*XLEN-1:0];
        stage2_op_q   <= stage1_op_q;
        stage2_id_q   <= stage1_id_q;
    end

    // Low word for MUL and high word for the MULH variants
    assign result_o        = (stage2_op_q == OP_MUL) ? stage2_prod_q[XLEN-1:0]
                                                     : stage2_prod_q[2*XLEN-1:XLEN];
    assign mult_valid_o    = stage2_valid_q;
    assign mult_trans_id_o = stage2_id_q;

    // Issuer holds multiplies back while the pipeline is flushed
    no_issue_on_flush_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) flush_i |-> !mult_valid_i
    ) else $error("multiply issued in the same cycle as a flush");

endmodule

//--- run.sh
#!/bin/sh
# Build the ex_stage testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_ex_stage -f vlog.f \
    && ./obj_dir/Vtb_ex_stage > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- vlog.f
common/ex_pkg.sv
logic/alu.sv
multiplier/mult_pipe.sv
logic/csr_buffer.sv
logic/flu_writeback.sv
logic/ex_stage.sv
bench/tb_ex_stage.sv
